/* src/addMulPPGen.sv */
`default_nettype none

module addMulPPGen (
	input  logic [addMulPkg::widthX-1:0] xs,
	input  logic [addMulPkg::widthX-1:0] xc,
	input  logic [addMulPkg::widthY-1:0] y,
	output logic [addMulPkg::ppRows*addMulPkg::widthP-1:0] pp
);

	// width of one selected multiple, 2y needs one extra bit
	localparam int multW = addMulPkg::widthY + 1;
	// sign-extension bits above a multiple
	localparam int extW = addMulPkg::widthP - multW;
	// index of the negatively weighted digit
	localparam int topI = addMulPkg::widthX - 1;

	// digit flags per bit pair
	logic [addMulPkg::widthX-1:0] m1;
	logic [addMulPkg::widthX-1:0] m2;
	// y and 2y, both sign-extended to multW
	logic [multW-1:0] yOne;
	logic [multW-1:0] yTwo;
	// one's complements for the top digit
	logic [multW-1:0] yOneN;
	logic [multW-1:0] yTwoN;
	logic [addMulPkg::widthP-1:0] rows [addMulPkg::ppRows];

	////////////////////////////////////////////////////////////////////////////
	// digit recoding
	// digit = xs[i] + xc[i], so m1 means 1 and m2 means 2
	assign m1 = xs ^ xc;
	assign m2 = xs & xc;

	assign yOne  = {y[addMulPkg::widthY-1], y};
	assign yTwo  = {y, 1'b0};
	assign yOneN = ~yOne;
	assign yTwoN = ~yTwo;

	////////////////////////////////////////////////////////////////////////////
	// row generation
	for (genvar i = 0; i < addMulPkg::widthX; i++) begin : genRow
		logic [multW-1:0] mult;
		if (i < topI) begin : genPos
			// positive weight, select 0, y or 2y then sign-extend and shift
			assign mult = ({multW{m1[i]}} & yOne) | ({multW{m2[i]}} & yTwo);
			assign rows[i] = {{extW{mult[multW-1]}}, mult} << i;
		end else begin : genNeg
			// negative weight, complement now and add the missing ones below
			assign mult = ({multW{m1[i]}} & yOneN) | ({multW{m2[i]}} & yTwoN);
			// top row reaches bit widthP-1 exactly, no extension
			assign rows[i] = {mult, {i{1'b0}}};
		end
	end

	// correction row
	// ~y and ~(2y) both miss a single one at the top digit weight
	assign rows[addMulPkg::widthX] = {{(addMulPkg::widthP-topI-1){1'b0}},
		m2[topI] | m1[topI], {topI{1'b0}}};

	// flatten rows, row 0 in the low bits
	for (genvar r = 0; r < addMulPkg::ppRows; r++) begin : genPack
		assign pp[r*addMulPkg::widthP +: addMulPkg::widthP] = rows[r];
	end

endmodule

`default_nettype wire

/* src/addMulPkg.sv */
`default_nettype none

package addMulPkg;

	// multiplier words xs and xc
	localparam int widthX = 8;
	// multiplicand y
	localparam int widthY = 8;
	// product and accumulator width
	localparam int widthP = widthX + widthY;
	// one row per multiplier bit plus the correction row
	localparam int ppRows = widthX + 1;

	// opMul returns the product, opMac folds it into the accumulator
	typedef enum logic {
		opMul = 1'b0,
		opMac = 1'b1
	} addMulOp_e;

	// request at the top-level input, 25 bits
	typedef struct packed {
		addMulOp_e op;
		logic [widthX-1:0] xs;
		logic [widthX-1:0] xc;
		logic [widthY-1:0] y;
	} addMulReq_t;

	// carry-save pair in flight, 33 bits
	typedef struct packed {
		addMulOp_e op;
		logic [widthP-1:0] sum;
		logic [widthP-1:0] carry;
	} csWord_t;

endpackage

`default_nettype wire

/* src/addMulTop.sv */
`default_nettype none

module addMulTop #(
	parameter int pipeDepth = 1
) (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	input  addMulPkg::addMulReq_t req,
	output logic outValid,
	output logic [addMulPkg::widthP-1:0] result
);

	// producer to buffer
	logic csValid;
	addMulPkg::csWord_t cs;
	// buffer to consumer
	logic bufValid;
	addMulPkg::csWord_t bufCs;

	// request capture, generation and reduction, 1 cycle
	ppProducer ppProducer_i (
		.clk     (clk),
		.rstN    (rstN),
		.inValid (inValid),
		.req     (req),
		.csValid (csValid),
		.cs      (cs)
	);

	// delay chain, pipeDepth cycles
	csBuffer #(
		.pipeDepth (pipeDepth)
	) csBuffer_i (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (csValid),
		.inWord   (cs),
		.outValid (bufValid),
		.outWord  (bufCs)
	);

	// final add and accumulate, 1 cycle
	macConsumer macConsumer_i (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (bufValid),
		.inWord   (bufCs),
		.outValid (outValid),
		.result   (result)
	);

endmodule

`default_nettype wire

/* src/csBuffer.sv */
`default_nettype none

module csBuffer #(
	parameter int pipeDepth = 1
) (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	input  addMulPkg::csWord_t inWord,
	output logic outValid,
	output addMulPkg::csWord_t outWord
);

	// stage 0 is nearest the input
	addMulPkg::csWord_t wordQ [pipeDepth];
	logic [pipeDepth-1:0] validQ;

	// valid shift chain
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= '0;
		end else begin
			validQ[0] <= inValid;
			for (int i = 1; i < pipeDepth; i++) begin
				validQ[i] <= validQ[i-1];
			end
		end
	end

	// word shift chain
	// shifts every cycle so words keep lockstep with their valid bits
	always_ff @(posedge clk) begin
		wordQ[0] <= inWord;
		for (int i = 1; i < pipeDepth; i++) begin
			wordQ[i] <= wordQ[i-1];
		end
	end

	// last stage drives the consumer
	assign outValid = validQ[pipeDepth-1];
	assign outWord  = wordQ[pipeDepth-1];

endmodule

`default_nettype wire

/* src/macConsumer.sv */
`default_nettype none

module macConsumer (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	input  addMulPkg::csWord_t inWord,
	output logic outValid,
	output logic [addMulPkg::widthP-1:0] result
);

	// running total
	logic [addMulPkg::widthP-1:0] accQ;
	// resolved product
	logic [addMulPkg::widthP-1:0] product;
	// accumulator plus product
	logic [addMulPkg::widthP-1:0] accNext;

	////////////////////////////////////////////////////////////////////////////
	// final carry-propagate adds
	// both wrap modulo 2^widthP
	assign product = inWord.sum + inWord.carry;
	assign accNext = accQ + product;

	////////////////////////////////////////////////////////////////////////////
	// accumulator and result register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			accQ     <= '0;
			result   <= '0;
			outValid <= 1'b0;
		end else begin
			outValid <= inValid;
			if (inValid) begin
				case (inWord.op)
					addMulPkg::opMac: begin
						// total becomes the result
						accQ   <= accNext;
						result <= accNext;
					end
					default: begin
						// plain product, accumulator untouched
						result <= product;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* src/ppProducer.sv */
`default_nettype none

module ppProducer (
	input  logic clk,
	input  logic rstN,
	input  logic inValid,
	input  addMulPkg::addMulReq_t req,
	output logic csValid,
	output addMulPkg::csWord_t cs
);

	// captured request
	addMulPkg::addMulReq_t reqQ;
	logic reqValidQ;
	// flat partial-product rows
	logic [addMulPkg::ppRows*addMulPkg::widthP-1:0] pp;
	// reduced pair before the output register
	logic [addMulPkg::widthP-1:0] ppSum;
	logic [addMulPkg::widthP-1:0] ppCarry;

	// strobes, one per stage
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			reqValidQ <= 1'b0;
			csValid   <= 1'b0;
		end else begin
			reqValidQ <= inValid;
			csValid   <= reqValidQ;
		end
	end

	// input register
	always_ff @(posedge clk) begin
		if (inValid) begin
			reqQ <= req;
		end
	end

	// combinational generation and reduction
	addMulPPGen addMulPPGen_i (
		.xs (reqQ.xs),
		.xc (reqQ.xc),
		.y  (reqQ.y),
		.pp (pp)
	);

	ppReduce ppReduce_i (
		.pp    (pp),
		.sum   (ppSum),
		.carry (ppCarry)
	);

	// output register, opcode rides along with the pair
	always_ff @(posedge clk) begin
		if (reqValidQ) begin
			cs.op    <= reqQ.op;
			cs.sum   <= ppSum;
			cs.carry <= ppCarry;
		end
	end

endmodule

`default_nettype wire

/* src/ppReduce.sv */
`default_nettype none

module ppReduce (
	input  logic [addMulPkg::ppRows*addMulPkg::widthP-1:0] pp,
	output logic [addMulPkg::widthP-1:0] sum,
	output logic [addMulPkg::widthP-1:0] carry
);

	// rows left after the given number of 3:2 levels
	function automatic int rowsAt(input int level);
		int n;
		n = addMulPkg::ppRows;
		for (int i = 0; i < level; i++) begin
			n = n - n / 3;
		end
		return n;
	endfunction

	// levels until two rows remain
	function automatic int levelCount();
		int n;
		int l;
		n = addMulPkg::ppRows;
		l = 0;
		while (n > 2) begin
			n = n - n / 3;
			l++;
		end
		return l;
	endfunction

	localparam int numLevels = levelCount();

	// row storage per level, only the first rowsAt(l) entries carry data
	logic [addMulPkg::widthP-1:0] lvl [numLevels+1][addMulPkg::ppRows];

	// level 0 straight from the generator
	for (genvar r = 0; r < addMulPkg::ppRows; r++) begin : genIn
		assign lvl[0][r] = pp[r*addMulPkg::widthP +: addMulPkg::widthP];
	end

	////////////////////////////////////////////////////////////////////////////
	// carry-save levels
	for (genvar l = 0; l < numLevels; l++) begin : genLevel
		localparam int rowsIn = rowsAt(l);
		localparam int groups = rowsIn / 3;
		localparam int rowsOut = rowsAt(l + 1);

		// one full-adder row per group of three
		for (genvar g = 0; g < groups; g++) begin : genCsa
			logic [addMulPkg::widthP-1:0] a;
			logic [addMulPkg::widthP-1:0] b;
			logic [addMulPkg::widthP-1:0] c;
			logic [addMulPkg::widthP-1:0] maj;
			assign a = lvl[l][3*g];
			assign b = lvl[l][3*g+1];
			assign c = lvl[l][3*g+2];
			assign maj = (a & b) | (a & c) | (b & c);
			assign lvl[l+1][2*g] = a ^ b ^ c;
			// carries move up one bit, the top one falls off
			assign lvl[l+1][2*g+1] = {maj[addMulPkg::widthP-2:0], 1'b0};
		end

		// leftover rows pass through untouched
		for (genvar r = 3 * groups; r < rowsIn; r++) begin : genPass
			assign lvl[l+1][r-groups] = lvl[l][r];
		end

		// idle slots of the next level
		for (genvar r = rowsOut; r < addMulPkg::ppRows; r++) begin : genIdle
			assign lvl[l+1][r] = '0;
		end
	end

	assign sum   = lvl[numLevels][0];
	assign carry = lvl[numLevels][1];

endmodule

`default_nettype wire

/* tb.f */
src/addMulPkg.sv
src/addMulPPGen.sv
src/ppReduce.sv
src/ppProducer.sv
src/csBuffer.sv
src/macConsumer.sv
src/addMulTop.sv
verif/addMul_assert.sv
verif/addMulTb.sv

/* verif/addMulTb.sv */
`default_nettype none

module addMulTb;

	localparam int seed = 51597;
	localparam int pipeDepth = 1;
	// edges from request to result
	localparam int lat = pipeDepth + 2;
	localparam int dirCount = 8;
	localparam int burstCount = 200;
	localparam int mixCount = 120;
	localparam int maxGap = 3;
	localparam int wrapCount = 16;
	localparam int rstRunCount = 16;
	localparam int testCount = 5;
	// directed requests wait for the full latency, mixed ones for their gaps
	localparam int timeoutCycles = dirCount * (lat + 3) + burstCount
		+ mixCount * (maxGap + 1) + wrapCount + rstRunCount + testCount * 20;

	logic clk = 1'b0;
	logic rstN;
	logic inValid;
	addMulPkg::addMulReq_t req;
	logic outValid;
	logic [addMulPkg::widthP-1:0] result;

	// expected results in request order
	logic [addMulPkg::widthP-1:0] expQ [$];
	logic [addMulPkg::widthP-1:0] modelAcc;
	int passCount;
	int failCount;
	int cycleCount = 0;

	addMulTop #(
		.pipeDepth (pipeDepth)
	) addMulTop_i (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.req      (req),
		.outValid (outValid),
		.result   (result)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model
	// signed (xs + xc) * y, low widthP bits, opMac folds into modelAcc
	function automatic logic [addMulPkg::widthP-1:0] refResult(
		input addMulPkg::addMulOp_e op,
		input logic [addMulPkg::widthX-1:0] xs,
		input logic [addMulPkg::widthX-1:0] xc,
		input logic [addMulPkg::widthY-1:0] y
	);
		int sumX;
		int prod;
		logic [addMulPkg::widthP-1:0] p;
		sumX = $signed(xs) + $signed(xc);
		prod = sumX * $signed(y);
		p = prod[addMulPkg::widthP-1:0];
		if (op == addMulPkg::opMac) begin
			modelAcc = modelAcc + p;
			return modelAcc;
		end
		return p;
	endfunction

	// drive one request just after the edge and queue its expected value
	task automatic sendReq(
		input addMulPkg::addMulOp_e op,
		input logic [addMulPkg::widthX-1:0] xs,
		input logic [addMulPkg::widthX-1:0] xc,
		input logic [addMulPkg::widthY-1:0] y
	);
		@(posedge clk);
		#1;
		inValid = 1'b1;
		req.op = op;
		req.xs = xs;
		req.xc = xc;
		req.y = y;
		expQ.push_back(refResult(op, xs, xc, y));
	endtask

	task automatic sendRandom(input addMulPkg::addMulOp_e op);
		sendReq(op, $urandom, $urandom, $urandom);
	endtask

	task automatic idleCycle();
		@(posedge clk);
		#1;
		inValid = 1'b0;
	endtask

	// wait for the outstanding results, bounded
	task automatic drain();
		int waited;
		waited = 0;
		idleCycle();
		while (expQ.size() != 0 && waited < lat + 10) begin
			@(posedge clk);
			waited++;
		end
		if (expQ.size() != 0) begin
			$display("error at time %0t: %0d results never came out", $time, expQ.size());
			failCount++;
			expQ.delete();
		end
	endtask

	task automatic reportTest(input string name, input int passMark, input int failMark);
		$display("test %s finished: %0d passed, %0d failed", name,
			passCount - passMark, failCount - failMark);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// comparator
	// samples at the falling edge, away from the register updates
	always @(negedge clk) begin : compare
		logic [addMulPkg::widthP-1:0] expVal;
		if (outValid) begin
			if (expQ.size() == 0) begin
				$display("error at time %0t: a result came out with no request waiting", $time);
				failCount++;
			end else begin
				expVal = expQ.pop_front();
				if (result !== expVal) begin
					$display("[FAIL] time %0t: result expected %h, got %h", $time, expVal,
						result);
					failCount++;
				end else begin
					passCount++;
				end
			end
		end
	end

	initial begin : timeout
		wait (cycleCount >= timeoutCycles);
		$display("timeout after %0d cycles, the run did not finish", cycleCount);
		$display("RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	initial begin : mainSeq
		int seedVal;
		int passMark;
		int failMark;
		int gap;
		logic [addMulPkg::widthX-1:0] dirXs [dirCount];
		logic [addMulPkg::widthX-1:0] dirXc [dirCount];
		logic [addMulPkg::widthY-1:0] dirY [dirCount];
		seedVal = $urandom(seed);
		inValid = 1'b0;
		req = '0;
		rstN = 1'b1;
		modelAcc = '0;
		passCount = 0;
		failCount = 0;
		// zeros, +1, -1, most negative multiplier pair and multiplicand
		dirXs = '{8'h00, 8'h01, 8'h00, 8'hff, 8'h80, 8'h80, 8'h7f, 8'h01};
		dirXc = '{8'h00, 8'h00, 8'h01, 8'hff, 8'h80, 8'h80, 8'h7f, 8'h01};
		dirY  = '{8'h00, 8'h01, 8'hff, 8'hff, 8'h01, 8'h80, 8'h80, 8'h80};
		#1;
		rstN = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;

		// directed, one request at a time
		passMark = passCount;
		failMark = failCount;
		for (int i = 0; i < dirCount; i++) begin
			sendReq(addMulPkg::opMul, dirXs[i], dirXc[i], dirY[i]);
			drain();
		end
		reportTest("directed corners", passMark, failMark);

		// back-to-back burst, pipeline full
		passMark = passCount;
		failMark = failCount;
		for (int i = 0; i < burstCount; i++) begin
			sendRandom(addMulPkg::opMul);
		end
		drain();
		reportTest("random burst", passMark, failMark);

		// mixed ops with gaps
		passMark = passCount;
		failMark = failCount;
		for (int i = 0; i < mixCount; i++) begin
			sendRandom(addMulPkg::addMulOp_e'($urandom_range(0, 1)));
			gap = $urandom_range(0, maxGap);
			repeat (gap) idleCycle();
		end
		drain();
		reportTest("mixed mul and mac", passMark, failMark);

		// large products push the accumulator around 2^widthP
		passMark = passCount;
		failMark = failCount;
		for (int i = 0; i < wrapCount / 2; i++) begin
			sendReq(addMulPkg::opMac, 8'h7f, 8'h7f, 8'h7f);
		end
		for (int i = 0; i < wrapCount / 2; i++) begin
			sendReq(addMulPkg::opMac, 8'h80, 8'h80, 8'h7f);
		end
		drain();
		reportTest("accumulator wrap", passMark, failMark);

		// reset while words are in flight
		passMark = passCount;
		failMark = failCount;
		for (int i = 0; i < rstRunCount / 2; i++) begin
			sendRandom(addMulPkg::opMac);
		end
		@(posedge clk);
		#1;
		inValid = 1'b0;
		rstN = 1'b0;
		expQ.delete();
		modelAcc = '0;
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		// nothing may come out before new requests
		repeat (lat + 3) begin
			@(negedge clk);
			if (outValid) begin
				$display("error at time %0t: outValid high after reset with no request", $time);
				failCount++;
			end else begin
				passCount++;
			end
		end
		for (int i = 0; i < rstRunCount / 2; i++) begin
			sendRandom(addMulPkg::opMac);
		end
		drain();
		reportTest("reset mid-run", passMark, failMark);

		if (expQ.size() != 0) begin
			$display("error: %0d expected results left over at the end", expQ.size());
			failCount++;
		end
		$display("checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/addMul_assert.sv */
`default_nettype none

module addMulAssert #(
	parameter int pipeDepth = 1
) (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic outValid,
	input logic [addMulPkg::widthP-1:0] result
);

	// edges from the sampling edge to the result register
	localparam int lat = pipeDepth + 2;

	// edges since reset release, saturates once history is clean
	int rstAge;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rstAge <= 0;
		end else if (rstAge < lat + 1) begin
			rstAge <= rstAge + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// timing
	// outValid is seen one edge after it is registered, hence lat + 1
	latencyCheck: assert property (@(posedge clk) disable iff (!rstN)
		(rstAge == lat + 1) |-> (outValid == $past(inValid, lat + 1)))
		else $error("outValid does not follow inValid by the pipeline latency");

	resultKnown: assert property (@(posedge clk) disable iff (!rstN)
		outValid |-> !$isunknown(result))
		else $error("result unknown while outValid is high");

	// reset behavior
	quietInReset: assert property (@(posedge clk) !rstN |-> !outValid)
		else $error("outValid high during reset");

endmodule

bind addMulTop addMulAssert #(
	.pipeDepth (pipeDepth)
) addMulAssert_i (
	.clk      (clk),
	.rstN     (rstN),
	.inValid  (inValid),
	.outValid (outValid),
	.result   (result)
);

`default_nettype wire
